// ==== design/rv_pkg.sv ====
/* Shared types for the RV32I subset core: opcodes, ALU operations, the
   instruction word views, decoded control and the memory bus structs */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes handled by the core, everything else is illegal
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  //////////////////////////////
  // Instruction formats
  //////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_s_t;

  // Branch offset is scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_j_t;

  // One fetched word, read through whichever format its opcode selects
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_u;

  //////////////////////////////
  // Control and bus structs
  //////////////////////////////

  typedef struct packed {
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  rf_we;
    logic                  mem_req;
    logic                  mem_we;
    logic                  is_branch;
    logic                  branch_ne;
    logic                  is_jal;
    logic [REG_ADDR_W-1:0] rd;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [3:0]      be;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== design/rv_alu.sv ====
/* Combinational ALU for the supported integer operations, with an
   equality flag that the branch logic reads */
module rv_alu (
  input  rv_pkg::alu_op_e         op_i,
  input  logic [rv_pkg::XLEN-1:0] a_i,
  input  logic [rv_pkg::XLEN-1:0] b_i,
  output logic [rv_pkg::XLEN-1:0] result_o,
  output logic                    equal_o
);

  always_comb begin
    case (op_i)
      rv_pkg::ALU_ADD:    result_o = a_i + b_i;
      rv_pkg::ALU_SUB:    result_o = a_i - b_i;
      rv_pkg::ALU_AND:    result_o = a_i & b_i;
      rv_pkg::ALU_OR:     result_o = a_i | b_i;
      rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      // LUI passes its immediate straight through
      rv_pkg::ALU_PASS_B: result_o = b_i;
      default:            result_o = '0;
    endcase
  end

  // BEQ/BNE decide on this flag alone
  assign equal_o = (a_i == b_i);

endmodule

// ==== design/rv_register_file.sv ====
/* Integer register file with two combinational read ports and one
   write port; x0 is not stored and always reads zero */
module rv_register_file (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic                          we_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i,
  output logic [rv_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_pkg::XLEN-1:0]       rdata_b_o
);

  // Only x1..x31 exist as storage
  logic [rv_pkg::XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 1; r < 32; r++) begin
        regs_q[r] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== design/rv_decoder.sv ====
/* Combinational decoder: turns the fetched word into control bits,
   register indices and the sign-extended immediate of its format */
module rv_decoder (
  input  rv_pkg::instr_u                instr_i,
  output rv_pkg::ctrl_t                 ctrl_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv_pkg::XLEN-1:0]       imm_o,
  output logic                          illegal_o
);

  logic [rv_pkg::XLEN-1:0] imm_i_type;
  logic [rv_pkg::XLEN-1:0] imm_s_type;
  logic [rv_pkg::XLEN-1:0] imm_b_type;
  logic [rv_pkg::XLEN-1:0] imm_u_type;
  logic [rv_pkg::XLEN-1:0] imm_j_type;

  // Register fields sit at the same bits in every format
  assign rs1_o = instr_i.r.rs1;
  assign rs2_o = instr_i.r.rs2;

  // Rebuild each immediate layout, sign bit is always instruction bit 31
  assign imm_i_type = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s_type = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_b_type = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                       instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
  assign imm_u_type = {instr_i.u.imm, 12'b0};
  assign imm_j_type = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                       instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = rv_pkg::ALU_ADD;
    ctrl_o.rd     = instr_i.r.rd;
    imm_o         = '0;
    illegal_o     = 1'b0;

    case (instr_i.r.opcode)
      rv_pkg::OP: begin
        ctrl_o.rf_we = 1'b1;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'b0000000, 3'b000}: ctrl_o.alu_op = rv_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = rv_pkg::ALU_SUB;
          {7'b0000000, 3'b100}: ctrl_o.alu_op = rv_pkg::ALU_XOR;
          {7'b0000000, 3'b110}: ctrl_o.alu_op = rv_pkg::ALU_OR;
          {7'b0000000, 3'b111}: ctrl_o.alu_op = rv_pkg::ALU_AND;
          default:              illegal_o     = 1'b1;
        endcase
      end
      rv_pkg::OP_IMM: begin
        // ADDI only
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.use_imm = 1'b1;
        imm_o          = imm_i_type;
        illegal_o      = (instr_i.i.funct3 != 3'b000);
      end
      rv_pkg::LUI: begin
        ctrl_o.alu_op  = rv_pkg::ALU_PASS_B;
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.use_imm = 1'b1;
        imm_o          = imm_u_type;
      end
      rv_pkg::LOAD: begin
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.mem_req = 1'b1;
        imm_o          = imm_i_type;
        illegal_o      = (instr_i.i.funct3 != 3'b010);
      end
      rv_pkg::STORE: begin
        ctrl_o.use_imm = 1'b1;
        ctrl_o.mem_req = 1'b1;
        ctrl_o.mem_we  = 1'b1;
        imm_o          = imm_s_type;
        illegal_o      = (instr_i.s.funct3 != 3'b010);
      end
      rv_pkg::BRANCH: begin
        // BEQ and BNE, compare rs1 against rs2
        ctrl_o.is_branch = 1'b1;
        ctrl_o.branch_ne = instr_i.b.funct3[0];
        imm_o            = imm_b_type;
        illegal_o        = (instr_i.b.funct3[2:1] != 2'b00);
      end
      rv_pkg::JAL: begin
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.is_jal = 1'b1;
        imm_o         = imm_j_type;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== design/rv_if_stage.sv ====
/* Fetch stage: holds the PC, runs the instruction bus handshake and
   keeps the fetched word for the decoder until the next fetch */
module rv_if_stage #(
  parameter logic [rv_pkg::XLEN-1:0] BootAddr = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    fetch_start_i,
  input  logic                    pc_load_i,
  input  logic [rv_pkg::XLEN-1:0] pc_target_i,
  input  rv_pkg::mem_rsp_t        instr_rsp_i,
  output logic                    instr_req_valid_o,
  output rv_pkg::mem_req_t        instr_req_o,
  output rv_pkg::instr_u          instr_o,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic                    fetch_done_o
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic                    req_q;
  logic                    wait_q;
  logic                    launch;
  rv_pkg::instr_u          instr_q;

  // A start is only taken with no request or response pending
  assign launch = fetch_start_i && !req_q && !wait_q;

  // Valid goes up in the start cycle, then held by req_q until gnt
  assign instr_req_valid_o = launch || req_q;
  assign fetch_done_o      = wait_q && instr_rsp_i.rvalid;

  // Read-only word access at the current PC
  always_comb begin
    instr_req_o       = '0;
    instr_req_o.addr  = pc_q;
    instr_req_o.we    = 1'b0;
    instr_req_o.be    = 4'b1111;
    instr_req_o.wdata = '0;
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (instr_req_valid_o && instr_rsp_i.gnt) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end else if (launch) begin
        req_q <= 1'b1;
      end
      if (fetch_done_o) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Sequential advance at fetch end, jumps and taken branches override
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= BootAddr;
    end else if (pc_load_i) begin
      pc_q <= pc_target_i;
    end else if (fetch_done_o) begin
      pc_q <= pc_q + rv_pkg::XLEN'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done_o) begin
      instr_q <= instr_rsp_i.rdata;
    end
  end

  assign instr_o = instr_q;
  assign pc_o    = pc_q;

endmodule

// ==== design/rv_load_store_unit.sv ====
/* Data bus handshake for aligned word loads and stores; one access at a
   time, started by the core and finished when the response returns */
module rv_load_store_unit (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic                    we_i,
  input  logic [rv_pkg::XLEN-1:0] addr_i,
  input  logic [rv_pkg::XLEN-1:0] wdata_i,
  input  rv_pkg::mem_rsp_t        data_rsp_i,
  output logic                    data_req_valid_o,
  output rv_pkg::mem_req_t        data_req_o,
  output logic [rv_pkg::XLEN-1:0] rdata_o,
  output logic                    done_o
);

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
  } lsu_state_e;

  lsu_state_e       state_q;
  rv_pkg::mem_req_t req_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE: begin
          if (start_i) begin
            state_q <= LSU_REQ;
          end
        end
        LSU_REQ: begin
          if (data_rsp_i.gnt) begin
            state_q <= LSU_WAIT;
          end
        end
        LSU_WAIT: begin
          if (data_rsp_i.rvalid) begin
            state_q <= LSU_IDLE;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  // Request fields frozen at start, held through the grant wait
  always_ff @(posedge clk) begin
    if (start_i && (state_q == LSU_IDLE)) begin
      req_q.addr  <= {addr_i[rv_pkg::XLEN-1:2], 2'b00};
      req_q.we    <= we_i;
      req_q.be    <= 4'b1111;
      req_q.wdata <= wdata_i;
    end
  end

  assign data_req_valid_o = (state_q == LSU_REQ);
  assign data_req_o       = req_q;

  // Store responses carry no data, the core only writes back on loads
  assign done_o  = (state_q == LSU_WAIT) && data_rsp_i.rvalid;
  assign rdata_o = data_rsp_i.rdata;

endmodule

// ==== design/rv_core.sv ====
/* Top level of the non-pipelined RV32I subset core. Sequences fetch,
   execute and memory phases and exposes the two request/grant buses */
module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] BootAddr = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  rv_pkg::mem_rsp_t instr_rsp_i,
  input  rv_pkg::mem_rsp_t data_rsp_i,
  output logic             instr_req_valid_o,
  output rv_pkg::mem_req_t instr_req_o,
  output logic             data_req_valid_o,
  output rv_pkg::mem_req_t data_req_o,
  output logic             halted_o
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_HALT
  } state_e;

  state_e                        state_q;
  logic                          fetch_start;
  logic                          fetch_done;
  logic                          pc_load;
  logic [rv_pkg::XLEN-1:0]       pc_target;
  logic [rv_pkg::XLEN-1:0]       pc_if;
  logic [rv_pkg::XLEN-1:0]       pc_cur;
  rv_pkg::instr_u                instr;
  rv_pkg::ctrl_t                 ctrl;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic                          illegal;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;
  logic [rv_pkg::XLEN-1:0]       alu_b;
  logic [rv_pkg::XLEN-1:0]       alu_result;
  logic                          alu_equal;
  logic                          lsu_start;
  logic                          lsu_done;
  logic [rv_pkg::XLEN-1:0]       lsu_rdata;
  logic                          exec_ok;
  logic                          branch_taken;
  logic                          rf_we;
  logic [rv_pkg::XLEN-1:0]       rf_wdata;

  //////////////////////////////
  // Sequencing FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_FETCH;
    end else begin
      case (state_q)
        S_FETCH: if (fetch_done) state_q <= S_EXEC;
        S_EXEC: begin
          if (illegal) begin
            state_q <= S_HALT;
          end else if (ctrl.mem_req) begin
            state_q <= S_MEM;
          end else begin
            state_q <= S_FETCH;
          end
        end
        S_MEM:   if (lsu_done) state_q <= S_FETCH;
        default: state_q <= S_HALT;
      endcase
    end
  end

  // Held for the whole fetch phase, the fetch stage only acts when idle
  assign fetch_start = (state_q == S_FETCH) && fetch_enable_i;
  assign exec_ok     = (state_q == S_EXEC) && !illegal;
  assign lsu_start   = exec_ok && ctrl.mem_req;
  assign halted_o    = (state_q == S_HALT);

  //////////////////////////////
  // Next PC
  //////////////////////////////

  // The fetch stage has already stepped past this instruction
  assign pc_cur       = pc_if - rv_pkg::XLEN'(4);
  assign pc_target    = pc_cur + imm;
  assign branch_taken = ctrl.is_branch && (ctrl.branch_ne ? !alu_equal : alu_equal);
  assign pc_load      = exec_ok && (ctrl.is_jal || branch_taken);

  //////////////////////////////
  // Operands and writeback
  //////////////////////////////

  assign alu_b = ctrl.use_imm ? imm : rs2_data;

  // ALU, branch and jump results land in EXEC, loads on their rvalid
  assign rf_we = (exec_ok && ctrl.rf_we && !ctrl.mem_req) ||
                 ((state_q == S_MEM) && lsu_done && ctrl.rf_we);

  always_comb begin
    if (state_q == S_MEM) begin
      rf_wdata = lsu_rdata;
    end else if (ctrl.is_jal) begin
      rf_wdata = pc_if;
    end else begin
      rf_wdata = alu_result;
    end
  end

  rv_if_stage #(
    .BootAddr (BootAddr)
  ) u_if_stage (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .fetch_start_i     (fetch_start),
    .pc_load_i         (pc_load),
    .pc_target_i       (pc_target),
    .instr_rsp_i       (instr_rsp_i),
    .instr_req_valid_o (instr_req_valid_o),
    .instr_req_o       (instr_req_o),
    .instr_o           (instr),
    .pc_o              (pc_if),
    .fetch_done_o      (fetch_done)
  );

  rv_decoder u_decoder (
    .instr_i   (instr),
    .ctrl_o    (ctrl),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .imm_o     (imm),
    .illegal_o (illegal)
  );

  rv_register_file u_register_file (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (ctrl.rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  rv_alu u_alu (
    .op_i     (ctrl.alu_op),
    .a_i      (rs1_data),
    .b_i      (alu_b),
    .result_o (alu_result),
    .equal_o  (alu_equal)
  );

  rv_load_store_unit u_load_store_unit (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .start_i          (lsu_start),
    .we_i             (ctrl.mem_we),
    .addr_i           (alu_result),
    .wdata_i          (rs2_data),
    .data_rsp_i       (data_rsp_i),
    .data_req_valid_o (data_req_valid_o),
    .data_req_o       (data_req_o),
    .rdata_o          (lsu_rdata),
    .done_o           (lsu_done)
  );

endmodule

// ==== dv/rv_core_assertions.sv ====
/* Bus protocol and halt checks for the RV32I subset core, bound into
   rv_core by the testbench */
module rv_core_assertions (
  input logic             clk,
  input logic             rst_ni,
  input logic             instr_req_valid_o,
  input rv_pkg::mem_req_t instr_req_o,
  input rv_pkg::mem_rsp_t instr_rsp_i,
  input logic             data_req_valid_o,
  input rv_pkg::mem_req_t data_req_o,
  input rv_pkg::mem_rsp_t data_rsp_i,
  input logic             halted_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned error_count = 0;

  // A request waiting for gnt keeps valid and fields
  instr_req_held: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_valid_o && !instr_rsp_i.gnt |=> instr_req_valid_o && $stable(instr_req_o))
    else begin
      error_count++;
      $error("instruction request changed while waiting for gnt");
    end

  data_req_held: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_valid_o && !data_rsp_i.gnt |=> data_req_valid_o && $stable(data_req_o))
    else begin
      error_count++;
      $error("data request changed while waiting for gnt");
    end

  // Only one phase runs at a time
  one_bus_active: assert property (@(posedge clk) disable iff (!rst_ni)
    !(instr_req_valid_o && data_req_valid_o))
    else begin
      error_count++;
      $error("instruction and data requests valid in the same cycle");
    end

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_ni)
    halted_o |=> halted_o)
    else begin
      error_count++;
      $error("halted_o fell without a reset");
    end

endmodule

// ==== dv/rv_core_tb.sv ====
/* Testbench for the RV32I subset core. Runs a table of short programs on
   bus models with random gnt and rvalid delays, then checks the stored result */
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_ROWS       = 12;
  localparam int          PROG_WORDS     = 16;
  localparam int          ROM_WORDS      = 64;
  localparam int          RAM_WORDS      = 256;
  localparam int          CYCLES_PER_ROW = 200;
  localparam int          RESULT_ADDR    = 'h100;
  localparam logic [31:0] BOOT_ADDR      = 32'h0000_0200;
  localparam logic [31:0] ILLEGAL_WORD   = 32'h0000_0000;
  localparam logic [31:0] SEED           = 32'hf888;

  logic             clk;
  logic             rst_ni;
  logic             fetch_enable;
  rv_pkg::mem_rsp_t instr_rsp;
  rv_pkg::mem_rsp_t data_rsp;
  logic             instr_req_valid;
  rv_pkg::mem_req_t instr_req;
  logic             data_req_valid;
  rv_pkg::mem_req_t data_req;
  logic             halted;

  logic [31:0] rom [ROM_WORDS];
  logic [31:0] ram [RAM_WORDS];

  // Stimulus table with one program per row
  string       row_name   [NUM_ROWS];
  logic [31:0] row_prog   [NUM_ROWS][PROG_WORDS];
  int          row_addr   [NUM_ROWS];
  logic [31:0] row_expect [NUM_ROWS];
  int          num_rows;
  int          fail_count;
  int          cur_test;
  logic        bad_req;
  logic [31:0] prog_q [$];

  rv_core #(
    .BootAddr (BOOT_ADDR)
  ) dut (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .fetch_enable_i    (fetch_enable),
    .instr_rsp_i       (instr_rsp),
    .data_rsp_i        (data_rsp),
    .instr_req_valid_o (instr_req_valid),
    .instr_req_o       (instr_req),
    .data_req_valid_o  (data_req_valid),
    .data_req_o        (data_req),
    .halted_o          (halted)
  );

  bind rv_core rv_core_assertions u_assertions (.*);

  //////////////////////////////
  // RV32I encodings
  //////////////////////////////

  function automatic logic [31:0] alu_rr(int f7, int f3, int rd, int rs1, int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(int rd, int imm);
    return {20'(imm), 5'(rd), 7'b0110111};
  endfunction

  function automatic logic [31:0] lw(int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(int rs2, int rs1, int imm);
    logic [11:0] off;
    off = 12'(imm);
    return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011};
  endfunction

  // Byte offsets with bit 0 dropped by the format
  function automatic logic [31:0] branch(int f3, int rs1, int rs2, int offset);
    logic [12:0] off;
    off = 13'(offset);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'(f3), off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(int rd, int offset);
    logic [20:0] off;
    off = 21'(offset);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
  endfunction

  // Closes the program in prog_q with the result store and a stop word
  task automatic add_row(input string name, input int res_reg, input logic [31:0] exp);
    prog_q.push_back(sw(res_reg, 0, RESULT_ADDR));
    prog_q.push_back(ILLEGAL_WORD);
    row_name[num_rows]   = name;
    row_addr[num_rows]   = RESULT_ADDR;
    row_expect[num_rows] = exp;
    for (int i = 0; i < PROG_WORDS; i++) begin
      row_prog[num_rows][i] = (i < prog_q.size()) ? prog_q[i] : ILLEGAL_WORD;
    end
    num_rows++;
    prog_q.delete();
  endtask

  task automatic build_table();
    prog_q = '{addi(1, 0, 100), addi(2, 0, 23), alu_rr(0, 0, 3, 1, 2)};
    add_row("add", 3, 32'd100 + 32'd23);
    prog_q = '{addi(1, 0, 5), addi(2, 0, 12), alu_rr('h20, 0, 3, 1, 2)};
    add_row("sub", 3, 32'd5 - 32'd12);
    prog_q = '{addi(1, 0, -16), addi(2, 0, 'h3a5), alu_rr(0, 7, 3, 1, 2)};
    add_row("and", 3, 32'hffff_fff0 & 32'h0000_03a5);
    prog_q = '{addi(1, 0, 'h6c), addi(2, 0, 'h3a), alu_rr(0, 6, 3, 1, 2)};
    add_row("or", 3, 32'h6c | 32'h3a);
    prog_q = '{addi(1, 0, -1), addi(2, 0, 'h3a), alu_rr(0, 4, 3, 1, 2)};
    add_row("xor", 3, 32'hffff_ffff ^ 32'h3a);
    prog_q = '{addi(1, 0, 20), addi(1, 1, -300)};
    add_row("addi_neg", 1, 32'(20 - 300));
    prog_q = '{lui(1, 'habcde), addi(1, 1, 'h123)};
    add_row("lui", 1, 32'habcd_e123);
    prog_q = '{lui(1, 'h12345), addi(1, 1, 'h678), addi(2, 0, 'h40), sw(1, 2, 8), lw(3, 2, 8)};
    add_row("sw_lw", 3, 32'h1234_5678);
    // First compare falls through and the second skips the +2
    prog_q = '{addi(1, 0, 7), addi(2, 0, 7), addi(4, 0, 9), branch(0, 1, 4, 8),
               addi(3, 3, 4), branch(0, 1, 2, 8), addi(3, 3, 2)};
    add_row("beq", 3, 32'd4);
    prog_q = '{addi(1, 0, 7), addi(2, 0, 7), addi(4, 0, 9), branch(1, 1, 2, 8),
               addi(3, 3, 4), branch(1, 1, 4, 8), addi(3, 3, 2)};
    add_row("bne", 3, 32'd4);
    // JAL sits at word 1 so the link is the boot address plus 8
    prog_q = '{addi(3, 0, 5), jal(1, 8), addi(3, 0, 99), alu_rr(0, 0, 5, 1, 3)};
    add_row("jal", 5, BOOT_ADDR + 32'd8 + 32'd5);
    prog_q = '{addi(0, 0, 55), addi(1, 0, 3), alu_rr(0, 0, 1, 1, 0)};
    add_row("x0_write", 1, 32'd3);
  endtask

  //////////////////////////////
  // Bus models
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // gnt after 0..3 cycles and rvalid 1..3 cycles after gnt
  task automatic serve_instr();
    logic [31:0] rom_index;
    forever begin
      if (instr_req_valid) begin
        repeat ($urandom % 4) next_cycle();
        instr_rsp.gnt = 1'b1;
        rom_index     = (instr_req.addr - BOOT_ADDR) >> 2;
        if (instr_req.we !== 1'b0 || instr_req.be !== 4'b1111) begin
          bad_req = 1'b1;
          $display("ERROR %s: expected instruction we 0 be 0xf, actual we %0b be 0x%0h",
                   row_name[cur_test], instr_req.we, instr_req.be);
        end
        next_cycle();
        instr_rsp.gnt = 1'b0;
        repeat ($urandom % 3) next_cycle();
        instr_rsp.rvalid = 1'b1;
        instr_rsp.rdata  = rom[rom_index[5:0]];
        next_cycle();
        instr_rsp.rvalid = 1'b0;
      end else begin
        next_cycle();
      end
    end
  endtask

  task automatic serve_data();
    logic [7:0] index;
    forever begin
      if (data_req_valid) begin
        repeat ($urandom % 4) next_cycle();
        data_rsp.gnt = 1'b1;
        index        = data_req.addr[9:2];
        if (data_req.be !== 4'b1111) begin
          bad_req = 1'b1;
          $display("ERROR %s: expected data be 0xf, actual 0x%0h",
                   row_name[cur_test], data_req.be);
        end
        if (data_req.we) begin
          ram[index] = data_req.wdata;
        end
        next_cycle();
        data_rsp.gnt = 1'b0;
        repeat ($urandom % 3) next_cycle();
        data_rsp.rvalid = 1'b1;
        data_rsp.rdata  = ram[index];
        next_cycle();
        data_rsp.rvalid = 1'b0;
      end else begin
        next_cycle();
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  task automatic run_test(input int t);
    logic [31:0] actual;
    logic        late_req;
    cur_test     = t;
    bad_req      = 1'b0;
    rst_ni       = 1'b0;
    fetch_enable = 1'b0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = (i < PROG_WORDS) ? row_prog[t][i] : ILLEGAL_WORD;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram[i] = '0;
    end
    repeat (4) next_cycle();
    rst_ni = 1'b1;
    next_cycle();
    fetch_enable = 1'b1;
    while (!halted) begin
      next_cycle();
    end
    // Bus must stay quiet once halted
    late_req = 1'b0;
    repeat (4) begin
      next_cycle();
      if (instr_req_valid || data_req_valid) begin
        late_req = 1'b1;
      end
    end
    actual = ram[(row_addr[t] >> 2) % RAM_WORDS];
    if (actual !== row_expect[t]) begin
      fail_count++;
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", row_name[t], row_expect[t], actual);
    end else if (late_req) begin
      fail_count++;
      $display("test %s: the core issued a bus request after halting", row_name[t]);
    end else if (bad_req) begin
      fail_count++;
      $display("test %s: a bus request had wrong write or byte enable bits", row_name[t]);
    end else begin
      $display("test %s: ok", row_name[t]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    void'($urandom(SEED));
    rst_ni       = 1'b0;
    fetch_enable = 1'b0;
    instr_rsp    = '0;
    data_rsp     = '0;
    num_rows     = 0;
    fail_count   = 0;
    cur_test     = 0;
    bad_req      = 1'b0;
    build_table();
    fork
      serve_instr();
      serve_data();
    join_none
    for (int t = 0; t < num_rows; t++) begin
      run_test(t);
    end
    $display("tests run: %0d, failed: %0d, assertion failures: %0d",
             num_rows, fail_count, dut.u_assertions.error_count);
    if (fail_count == 0 && dut.u_assertions.error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    repeat (NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_ROWS * CYCLES_PER_ROW);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/rv_pkg.sv
design/rv_alu.sv
design/rv_register_file.sv
design/rv_decoder.sv
design/rv_if_stage.sv
design/rv_load_store_unit.sv
design/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv
